// File: cache_subsystem.f
src/cache_pkg.sv
src/mem_latency_timer.sv
src/cache_line_array.sv
src/main_memory.sv
src/cache_controller.sv
src/cache_subsystem.sv
tests/tb_clock_gen.sv
tests/tb_cache_subsystem.sv

// File: src/cache_controller.sv
// **************************************************
// One request in flight, access ignored while busy
// **************************************************

`timescale 1ns/1ps

module cache_controller #(
  parameter int INDEX_BITS = 2,
  localparam int TAG_BITS = cache_pkg::ADDR_BITS - cache_pkg::OFFSET_BITS - INDEX_BITS
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             access,
  input  cache_pkg::cache_op_t             op,
  input  logic                             byte_op,
  input  cache_pkg::addr_t                 address,
  input  cache_pkg::word_t                 data_in,
  input  logic                             tag_match,
  input  logic                             victim_dirty,
  input  logic [TAG_BITS-1:0]              victim_tag,
  input  logic                             expired,
  output logic [INDEX_BITS-1:0]            lookup_index,
  output logic [TAG_BITS-1:0]              lookup_tag,
  output logic [cache_pkg::OFFSET_BITS-1:0] req_offset,
  output logic                             req_byte_op,
  output cache_pkg::word_t                 req_data,
  output logic                             write_enable,
  output logic                             fill_enable,
  output logic                             start,
  output logic                             mem_read_enable,
  output logic                             mem_write_enable,
  output cache_pkg::mem_addr_t             mem_address,
  output logic                             hit,
  output logic                             miss,
  output logic                             done,
  output logic                             busy
);

  import cache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;

  // Latched request
  cache_op_t req_op;
  addr_t req_addr;

  // Request went to memory, so it does not count as a hit
  logic mem_used;
  // Fill data is sitting in the memory output register
  logic fill_ready;

  logic accept;

  assign accept = (state == ST_IDLE) && access;

  // Address fields of the latched request
  assign lookup_index = req_addr[OFFSET_BITS +: INDEX_BITS];
  assign lookup_tag = req_addr[ADDR_BITS-1 -: TAG_BITS];
  assign req_offset = req_addr[OFFSET_BITS-1:0];

  always_comb
  begin
    next_state = state;
    unique case (state)
      ST_IDLE:
        if (access)
          next_state = ST_LOOKUP;
      ST_LOOKUP:
        if (tag_match)
          next_state = ST_RESPOND;
        else if (victim_dirty)
          next_state = ST_WRITEBACK;
        else
          next_state = ST_FILL;
      ST_WRITEBACK:
        if (expired)
          next_state = ST_FILL;
      // Stays one cycle past expired to install the line
      ST_FILL:
        if (fill_ready)
          next_state = ST_RESPOND;
      ST_RESPOND:
        next_state = ST_IDLE;
      default:
        next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_IDLE;
      mem_used <= 1'b0;
      fill_ready <= 1'b0;
    end
    else
    begin
      state <= next_state;
      if (accept)
        mem_used <= 1'b0;
      else if (miss)
        mem_used <= 1'b1;
      fill_ready <= (state == ST_FILL) && expired;
    end
  end

  // Request payload, captured on acceptance
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_op <= op;
      req_byte_op <= byte_op;
      req_addr <= address;
      req_data <= data_in;
    end
  end

  // Timer runs once for write-back and once for fill
  assign start = ((state == ST_LOOKUP) && !tag_match)
              || ((state == ST_WRITEBACK) && expired);

  // Memory bus levels held for the whole transfer
  assign mem_write_enable = (state == ST_WRITEBACK);
  assign mem_read_enable = (state == ST_FILL) && !fill_ready;

  // Victim line address for write-back, request line otherwise
  assign mem_address = (state == ST_WRITEBACK) ? {victim_tag, lookup_index}
                                               : {lookup_tag, lookup_index};

  assign fill_enable = (state == ST_FILL) && fill_ready;

  // Stores merge on completion, also after write-allocate
  assign write_enable = (state == ST_RESPOND) && (req_op == OP_WRITE);

  // Processor side strobes
  assign miss = (state == ST_LOOKUP) && !tag_match;
  assign done = (state == ST_RESPOND);
  assign hit = (state == ST_RESPOND) && !mem_used;
  assign busy = (state != ST_IDLE);

endmodule

// File: src/cache_line_array.sv
// **************************************************
// Direct mapped, one line per index
// Word access ignores the two low offset bits
// **************************************************

`timescale 1ns/1ps

module cache_line_array #(
  parameter int INDEX_BITS = 2,
  localparam int TAG_BITS = cache_pkg::ADDR_BITS - cache_pkg::OFFSET_BITS - INDEX_BITS
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [INDEX_BITS-1:0]            lookup_index,
  input  logic [TAG_BITS-1:0]              lookup_tag,
  input  logic [cache_pkg::OFFSET_BITS-1:0] req_offset,
  input  logic                             req_byte_op,
  input  cache_pkg::word_t                 req_data,
  input  logic                             write_enable,
  input  logic                             fill_enable,
  input  cache_pkg::line_t                 fill_line,
  output logic                             tag_match,
  output logic                             victim_dirty,
  output logic [TAG_BITS-1:0]              victim_tag,
  output cache_pkg::line_t                 victim_line,
  output cache_pkg::word_t                 data_out
);

  import cache_pkg::*;

  localparam int LINES = 2 ** INDEX_BITS;

  // Per-line state bits
  logic [LINES-1:0] valid;
  logic [LINES-1:0] dirty;

  // Tag and data storage
  logic [TAG_BITS-1:0] tags [LINES];
  line_t lines [LINES];

  // Indexed line and its store-merged version
  line_t cur_line;
  line_t merged_line;
  word_t cur_word;

  assign cur_line = lines[lookup_index];

  // Hit needs a valid line with an equal tag
  assign tag_match = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

  // Line that a miss would replace
  assign victim_dirty = valid[lookup_index] && dirty[lookup_index];
  assign victim_tag = tags[lookup_index];
  assign victim_line = cur_line;

  // Word select uses offset bits 3:2 only
  assign cur_word = cur_line[{req_offset[3:2], 5'b00000} +: 32];

  // Byte reads come back zero-extended
  always_comb
  begin
    if (req_byte_op)
      data_out = {24'b0, cur_line[{req_offset, 3'b000} +: 8]};
    else
      data_out = cur_word;
  end

  // Store data merged into the current line
  always_comb
  begin
    merged_line = cur_line;
    if (req_byte_op)
      merged_line[{req_offset, 3'b000} +: 8] = req_data[7:0];
    else
      merged_line[{req_offset[3:2], 5'b00000} +: 32] = req_data;
  end

  // Valid and dirty bits
  // Fill gives a clean line, store marks it dirty
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else if (fill_enable)
    begin
      valid[lookup_index] <= 1'b1;
      dirty[lookup_index] <= 1'b0;
    end
    else if (write_enable)
      dirty[lookup_index] <= 1'b1;
  end

  // Tag and line payload
  always_ff @(posedge clk)
  begin
    if (fill_enable)
    begin
      tags[lookup_index] <= lookup_tag;
      lines[lookup_index] <= fill_line;
    end
    else if (write_enable)
      lines[lookup_index] <= merged_line;
  end

endmodule

// File: src/cache_pkg.sv
// **************************************************
// Widths fixed for a 4096-byte space and 16-byte lines
// Changing ADDR_BITS also resizes the main memory
// **************************************************

package cache_pkg;

  // Byte address width and line offset width
  localparam int ADDR_BITS = 12;
  localparam int OFFSET_BITS = 4;

  // Line address as seen on the memory bus
  localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

  // Number of lines held by main memory
  localparam int MEM_LINES = 2 ** LINE_ADDR_BITS;

  // Processor word, cache line and addresses
  typedef logic [31:0] word_t;
  typedef logic [127:0] line_t;
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [LINE_ADDR_BITS-1:0] mem_addr_t;

  // Processor operation
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_t;

  // Controller FSM states
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_LOOKUP    = 3'd1,
    ST_WRITEBACK = 3'd2,
    ST_FILL      = 3'd3,
    ST_RESPOND   = 3'd4
  } ctrl_state_t;

endpackage

// File: src/cache_subsystem.sv
// **************************************************
// Data cache plus main memory, single processor port
// **************************************************

`timescale 1ns/1ps

module cache_subsystem #(
  parameter int INDEX_BITS = 2,
  parameter int MEM_LATENCY = 5
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 access,
  input  cache_pkg::cache_op_t op,
  input  logic                 byte_op,
  input  cache_pkg::addr_t     address,
  input  cache_pkg::word_t     data_in,
  output cache_pkg::word_t     data_out,
  output logic                 hit,
  output logic                 miss,
  output logic                 done,
  output logic                 busy
);

  import cache_pkg::*;

  localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - INDEX_BITS;

  // Controller and array
  logic [INDEX_BITS-1:0] lookup_index;
  logic [TAG_BITS-1:0] lookup_tag;
  logic [OFFSET_BITS-1:0] req_offset;
  logic req_byte_op;
  word_t req_data;
  logic write_enable;
  logic fill_enable;
  logic tag_match;
  logic victim_dirty;
  logic [TAG_BITS-1:0] victim_tag;
  line_t victim_line;

  // Timer
  logic start;
  logic expired;

  // Memory bus
  logic mem_read_enable;
  logic mem_write_enable;
  mem_addr_t mem_address;
  line_t mem_data_out;

  cache_controller #(
    .INDEX_BITS(INDEX_BITS)
  ) controller_inst (
    .clk(clk),
    .reset(reset),
    .access(access),
    .op(op),
    .byte_op(byte_op),
    .address(address),
    .data_in(data_in),
    .tag_match(tag_match),
    .victim_dirty(victim_dirty),
    .victim_tag(victim_tag),
    .expired(expired),
    .lookup_index(lookup_index),
    .lookup_tag(lookup_tag),
    .req_offset(req_offset),
    .req_byte_op(req_byte_op),
    .req_data(req_data),
    .write_enable(write_enable),
    .fill_enable(fill_enable),
    .start(start),
    .mem_read_enable(mem_read_enable),
    .mem_write_enable(mem_write_enable),
    .mem_address(mem_address),
    .hit(hit),
    .miss(miss),
    .done(done),
    .busy(busy)
  );

  mem_latency_timer #(
    .MEM_LATENCY(MEM_LATENCY)
  ) timer_inst (
    .clk(clk),
    .reset(reset),
    .start(start),
    .expired(expired)
  );

  cache_line_array #(
    .INDEX_BITS(INDEX_BITS)
  ) array_inst (
    .clk(clk),
    .reset(reset),
    .lookup_index(lookup_index),
    .lookup_tag(lookup_tag),
    .req_offset(req_offset),
    .req_byte_op(req_byte_op),
    .req_data(req_data),
    .write_enable(write_enable),
    .fill_enable(fill_enable),
    .fill_line(mem_data_out),
    .tag_match(tag_match),
    .victim_dirty(victim_dirty),
    .victim_tag(victim_tag),
    .victim_line(victim_line),
    .data_out(data_out)
  );

  // Victim line goes straight onto the memory write bus
  main_memory memory_inst (
    .clk(clk),
    .read_enable(mem_read_enable),
    .write_enable(mem_write_enable),
    .expired(expired),
    .address(mem_address),
    .data_in(victim_line),
    .data_out(mem_data_out)
  );

endmodule

// File: src/main_memory.sv
// **************************************************
// Behavioral model, contents start at zero in simulation
// Acts only in the cycle that expired is high
// **************************************************

`timescale 1ns/1ps

module main_memory (
  input  logic                clk,
  input  logic                read_enable,
  input  logic                write_enable,
  input  logic                expired,
  input  cache_pkg::mem_addr_t address,
  input  cache_pkg::line_t    data_in,
  output cache_pkg::line_t    data_out
);

  import cache_pkg::*;

  // One entry per 16-byte line
  line_t mem [MEM_LINES];

  // Clear contents at time zero
  initial
  begin
    for (int i = 0; i < MEM_LINES; i++)
      mem[i] = '0;
  end

  // Write commits at the end of the timed transfer
  always @(posedge clk)
  begin
    if (expired && write_enable)
      mem[address] <= data_in;
  end

  // Read data registered at the end of the transfer
  // Held until the next read completes
  always_ff @(posedge clk)
  begin
    if (expired && read_enable)
      data_out <= mem[address];
  end

endmodule

// File: src/mem_latency_timer.sv
// **************************************************
// MEM_LATENCY must be at least 1
// **************************************************

`timescale 1ns/1ps

module mem_latency_timer #(
  parameter int MEM_LATENCY = 5
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic expired
);

  // Wide enough to hold the full latency value
  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  logic [CNT_BITS-1:0] count;

  // Load on start, count down to zero and then rest
  always_ff @(posedge clk)
  begin
    if (reset)
      count <= '0;
    else if (start)
      count <= CNT_BITS'(MEM_LATENCY);
    else if (count != '0)
      count <= count - 1'b1;
  end

  // Last cycle of the transfer
  // One pulse per start, silent while idle
  assign expired = (count == CNT_BITS'(1));

endmodule

// File: tests/tb_cache_subsystem.sv
// **************************************************
// Runs the DUT with default parameters, 4 lines
// Inputs change on the falling edge, outputs sampled there
// **************************************************

`timescale 1ns/1ps

module tb_cache_subsystem;

  import cache_pkg::*;

  // Upper bound for one request, well above a dirty miss
  localparam int DONE_TIMEOUT = 60;
  localparam int RANDOM_REQUESTS = 600;

  logic clk;
  logic reset;
  logic access;
  cache_op_t op;
  logic byte_op;
  addr_t address;
  word_t data_in;
  word_t data_out;
  logic hit;
  logic miss;
  logic done;
  logic busy;

  // Architectural byte image of the whole address space
  logic [7:0] model_mem [4096];
  // Tag and valid copy per cache index
  logic [5:0] model_tag [4];
  logic [3:0] model_valid;
  // Lines that hold stores not yet written back
  logic [3:0] model_dirty;

  logic [31:0] rng;
  // Few tags, so lines of one index conflict often
  logic [5:0] tag_set [3];
  // Dirty lines replaced during random traffic
  int evictions;

  tb_clock_gen #(
    .PERIOD_NS(4.0)
  ) clock_inst (
    .clk(clk)
  );

  cache_subsystem cache_subsystem_inst (
    .clk(clk),
    .reset(reset),
    .access(access),
    .op(op),
    .byte_op(byte_op),
    .address(address),
    .data_in(data_in),
    .data_out(data_out),
    .hit(hit),
    .miss(miss),
    .done(done),
    .busy(busy)
  );

  // 32-bit xorshift generator
  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Little endian word, or the byte zero-extended
  function automatic word_t model_read(input addr_t addr, input logic is_byte);
    int base;
    base = {addr[11:2], 2'b00};
    if (is_byte)
      return {24'b0, model_mem[addr]};
    return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
  endfunction

  task automatic model_write(input addr_t addr, input logic is_byte, input word_t value);
    int base;
    base = {addr[11:2], 2'b00};
    if (is_byte)
      model_mem[addr] = value[7:0];
    else
    begin
      for (int b = 0; b < 4; b++)
        model_mem[base + b] = value[8*b +: 8];
    end
  endtask

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      report_failure($sformatf("ERR %s expected 0x%08h actual 0x%08h", name, expected, actual));
  endtask

  // One request from strobe to done, then back to idle
  task automatic run_request(input string name, input logic is_write, input logic is_byte,
                             input addr_t addr, input word_t wdata, output word_t rdata);
    int idx;
    logic [5:0] tag;
    logic exp_hit;
    logic exp_miss;
    word_t exp_data;
    int cycles;
    idx = addr[5:4];
    tag = addr[11:6];
    exp_hit = model_valid[idx] && (model_tag[idx] == tag);
    exp_data = model_read(addr, is_byte);
    check_value({name, "_busy_before"}, 32'd0, {31'd0, busy});
    access = 1'b1;
    if (is_write)
      op = OP_WRITE;
    else
      op = OP_READ;
    byte_op = is_byte;
    address = addr;
    data_in = wdata;
    cycles = 0;
    do
    begin
      @(negedge clk);
      access = 1'b0;
      cycles++;
      // Miss pulses only in the lookup cycle
      exp_miss = (cycles == 1) && !exp_hit;
      check_value({name, "_miss"}, {31'd0, exp_miss}, {31'd0, miss});
      check_value({name, "_busy"}, 32'd1, {31'd0, busy});
      if (!done && cycles >= DONE_TIMEOUT)
        report_failure($sformatf("No done within %0d cycles for %s at address 0x%03h",
                                 DONE_TIMEOUT, name, addr));
    end
    while (!done);
    check_value({name, "_hit"}, {31'd0, exp_hit}, {31'd0, hit});
    // Hit latency is fixed
    if (exp_hit)
      check_value({name, "_hit_latency"}, 32'd2, cycles);
    rdata = data_out;
    if (!is_write)
      check_value({name, "_data"}, exp_data, data_out);
    else
      model_write(addr, is_byte, wdata);
    // Fill brings in a clean line and a store dirties it
    if (!exp_hit)
      model_dirty[idx] = 1'b0;
    if (is_write)
      model_dirty[idx] = 1'b1;
    // Write-allocate, so every access leaves its line resident
    model_valid[idx] = 1'b1;
    model_tag[idx] = tag;
    @(negedge clk);
  endtask

  initial
  begin
    word_t rd;
    word_t wd;
    addr_t a;
    logic [31:0] r;
    int idx;
    reset = 1'b1;
    access = 1'b0;
    op = OP_READ;
    byte_op = 1'b0;
    address = '0;
    data_in = '0;
    rng = 32'd12649;
    evictions = 0;
    tag_set[0] = 6'd0;
    tag_set[1] = 6'd1;
    tag_set[2] = 6'd45;
    model_valid = '0;
    model_dirty = '0;
    for (int i = 0; i < 4; i++)
      model_tag[i] = '0;
    for (int i = 0; i < 4096; i++)
      model_mem[i] = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // First touch of each index misses and reads zero
    for (int i = 0; i < 4; i++)
    begin
      a = {6'd0, 2'(i), 4'd0};
      run_request("reset_miss", 1'b0, 1'b0, a, '0, rd);
      check_value("reset_miss_zero", 32'd0, rd);
    end

    // Same lines again, all hits
    for (int i = 0; i < 4; i++)
    begin
      a = {6'd0, 2'(i), 4'd4};
      run_request("repeat_hit", 1'b0, 1'b0, a, '0, rd);
    end

    // Word and byte merge on one line
    run_request("word_write", 1'b1, 1'b0, 12'h010, 32'hA5A51234, rd);
    run_request("word_read", 1'b0, 1'b0, 12'h010, '0, rd);
    check_value("word_read_value", 32'hA5A51234, rd);
    run_request("byte_write", 1'b1, 1'b1, 12'h013, 32'h0000007E, rd);
    run_request("byte_read", 1'b0, 1'b1, 12'h013, '0, rd);
    check_value("byte_read_value", 32'h0000007E, rd);
    run_request("byte_neighbor", 1'b0, 1'b1, 12'h012, '0, rd);
    check_value("byte_neighbor_value", 32'h000000A5, rd);
    // Low address bits are ignored for words
    run_request("merged_word", 1'b0, 1'b0, 12'h011, '0, rd);
    check_value("merged_word_value", 32'h7EA51234, rd);

    // Mixed random traffic over conflicting tags
    for (int i = 0; i < RANDOM_REQUESTS; i++)
    begin
      rng = xorshift32(rng);
      r = rng;
      rng = xorshift32(rng);
      wd = rng;
      a = {tag_set[r[3:2] % 3], r[5:4], r[9:6]};
      idx = a[5:4];
      if (model_valid[idx] && model_dirty[idx] && model_tag[idx] != a[11:6])
        evictions++;
      run_request("random", r[10], r[11], a, wd, rd);
    end

    // Every word of the tag set, including evicted lines
    for (int t = 0; t < 3; t++)
    begin
      for (int w = 0; w < 16; w++)
      begin
        a = {tag_set[t], 4'(w), 2'b00};
        run_request("sweep_read", 1'b0, 1'b0, a, '0, rd);
      end
    end

    if (evictions == 0)
      report_failure("Random traffic never replaced a dirty line");
    else
    begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// File: tests/tb_clock_gen.sv
// **************************************************
// Free running clock, starts low at time zero
// **************************************************

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  // Half period per toggle
  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule
